// ==== build.f ====
+incdir+.
rs_pkg.sv
rs_entries.sv
rs_slot_alloc.sv
rs_issue_select.sv
rs.sv
rs_props.sv
tb_rs.sv

// ==== run.sh ====
#!/bin/sh
# build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rs -f build.f -o tb_rs
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_rs 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb_rs.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module tb_rs;

    localparam int D = `RS_DEPTH;
    localparam int W = `RS_WIDTH;
    localparam int NA = `RS_NUM_ALU;
    localparam int NM = `RS_NUM_MULT;
    localparam int NU = `RS_NUM_ALU + `RS_NUM_MULT + `RS_NUM_MEM;
    localparam logic [31:0] SEED = 32'heaf14f1f;
    localparam int RANDOM_CYCLES = 400;
    localparam int DRAIN_LIMIT = 200;

    logic                                           clock;
    logic                                           reset;
    logic [W-1:0]                                   dispatch_valid;
    logic [W-1:0][`RS_CLASS_BITS-1:0]               dispatch_class;
    logic [W-1:0][`RS_TAG_BITS-1:0]                 dispatch_dest;
    logic [W-1:0][`RS_TAG_BITS-1:0]                 dispatch_src1;
    logic [W-1:0]                                   dispatch_src1_ready;
    logic [W-1:0][`RS_TAG_BITS-1:0]                 dispatch_src2;
    logic [W-1:0]                                   dispatch_src2_ready;
    logic [W-1:0][`RS_PAYLOAD_BITS-1:0]             dispatch_payload;
    logic [`RS_CDB_PORTS-1:0]                       cdb_valid;
    logic [`RS_CDB_PORTS-1:0][`RS_TAG_BITS-1:0]     cdb_tag;
    logic [`RS_NUM_ALU-1:0]                         alu_busy;
    logic [`RS_NUM_MULT-1:0]                        mult_busy;
    logic [`RS_NUM_MEM-1:0]                         mem_busy;
    logic [`RS_OPEN_BITS-1:0]                       open_entries;
    logic [`RS_NUM_ALU-1:0]                         alu_issue_valid;
    logic [`RS_NUM_ALU-1:0][`RS_TAG_BITS-1:0]       alu_issue_dest;
    logic [`RS_NUM_ALU-1:0][`RS_PAYLOAD_BITS-1:0]   alu_issue_payload;
    logic [`RS_NUM_MULT-1:0]                        mult_issue_valid;
    logic [`RS_NUM_MULT-1:0][`RS_TAG_BITS-1:0]      mult_issue_dest;
    logic [`RS_NUM_MULT-1:0][`RS_PAYLOAD_BITS-1:0]  mult_issue_payload;
    logic [`RS_NUM_MEM-1:0]                         mem_issue_valid;
    logic [`RS_NUM_MEM-1:0][`RS_TAG_BITS-1:0]       mem_issue_dest;
    logic [`RS_NUM_MEM-1:0][`RS_PAYLOAD_BITS-1:0]   mem_issue_payload;

    // shadow slots
    logic [D-1:0]                       m_valid;
    logic [D-1:0]                       m_r1;
    logic [D-1:0]                       m_r2;
    logic [`RS_CLASS_BITS-1:0]          m_class [D];
    logic [`RS_TAG_BITS-1:0]            m_dest [D];
    logic [`RS_TAG_BITS-1:0]            m_src1 [D];
    logic [`RS_TAG_BITS-1:0]            m_src2 [D];
    logic [`RS_PAYLOAD_BITS-1:0]        m_payload [D];

    // units flattened as alu0, alu1, mult0, mem0
    logic [NU-1:0]                          busy_all;
    logic [NU-1:0]                          act_v;
    logic [NU-1:0][`RS_TAG_BITS-1:0]        act_dest;
    logic [NU-1:0][`RS_PAYLOAD_BITS-1:0]    act_payload;
    logic [NU-1:0]                          exp_v;
    logic [NU-1:0][`RS_TAG_BITS-1:0]        exp_dest;
    logic [NU-1:0][`RS_PAYLOAD_BITS-1:0]    exp_payload;
    logic [D-1:0]                           taken;
    logic [`RS_OPEN_BITS-1:0]               exp_open;

    logic [`RS_PAYLOAD_BITS-1:0]    next_payload;
    int                             dispatched_total;
    int                             issued_total;
    int                             seed_value;
    bit                             issued_seen [0:(1 << `RS_PAYLOAD_BITS) - 1];

    rs i_dut (.*);

    assign busy_all    = {mem_busy, mult_busy, alu_busy};
    assign act_v       = {mem_issue_valid, mult_issue_valid, alu_issue_valid};
    assign act_dest    = {mem_issue_dest, mult_issue_dest, alu_issue_dest};
    assign act_payload = {mem_issue_payload, mult_issue_payload, alu_issue_payload};

    function automatic logic [`RS_CLASS_BITS-1:0] unit_class(input int u);
        if (u < NA) begin
            return `RS_CLASS_ALU;
        end
        if (u < NA + NM) begin
            return `RS_CLASS_MULT;
        end
        return `RS_CLASS_MEM;
    endfunction

    function automatic string port_name(input int u, input string field);
        if (u < NA) begin
            return $sformatf("alu_issue_%s[%0d]", field, u);
        end
        if (u < NA + NM) begin
            return $sformatf("mult_issue_%s[%0d]", field, u - NA);
        end
        return $sformatf("mem_issue_%s[%0d]", field, u - NA - NM);
    endfunction

    function automatic logic on_cdb(input logic [`RS_TAG_BITS-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `RS_CDB_PORTS; p++) begin
            hit = hit | (cdb_valid[p] && cdb_tag[p] == tag);
        end
        return hit;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_text(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // each unit in order takes the lowest ready slot of its class still untaken
    always_comb begin
        int sel;
        taken = '0;
        for (int u = 0; u < NU; u++) begin
            sel = -1;
            for (int s = D - 1; s >= 0; s--) begin
                if (!busy_all[u] && m_valid[s] && m_r1[s] && m_r2[s]
                    && m_class[s] == unit_class(u) && !taken[s]) begin
                    sel = s;
                end
            end
            exp_v[u]       = 1'b0;
            exp_dest[u]    = '0;
            exp_payload[u] = '0;
            if (sel >= 0) begin
                exp_v[u]       = 1'b1;
                exp_dest[u]    = m_dest[sel];
                exp_payload[u] = m_payload[sel];
                taken[sel]     = 1'b1;
            end
        end
        exp_open = (D - $countones(m_valid) < W) ? `RS_OPEN_BITS'(D - $countones(m_valid))
                                                : `RS_OPEN_BITS'(W);
    end

    always @(posedge clock) begin
        int k;
        if (reset) begin
            m_valid <= '0;
        end else begin
            for (int u = 0; u < NU; u++) begin
                if (act_v[u]) begin
                    assert (!issued_seen[act_payload[u]])
                        else report_text("a payload was issued more than once");
                    issued_seen[act_payload[u]] = 1'b1;
                    issued_total++;
                end
            end
            for (int s = 0; s < D; s++) begin
                if (taken[s]) begin
                    m_valid[s] <= 1'b0;
                end
                if (on_cdb(m_src1[s])) begin
                    m_r1[s] <= 1'b1;
                end
                if (on_cdb(m_src2[s])) begin
                    m_r2[s] <= 1'b1;
                end
            end
            // lane k lands in the k-th lowest empty slot
            k = 0;
            for (int s = 0; s < D; s++) begin
                if (!m_valid[s] && k < W) begin
                    if (dispatch_valid[k]) begin
                        m_valid[s]   <= 1'b1;
                        m_class[s]   <= dispatch_class[k];
                        m_dest[s]    <= dispatch_dest[k];
                        m_src1[s]    <= dispatch_src1[k];
                        m_src2[s]    <= dispatch_src2[k];
                        m_payload[s] <= dispatch_payload[k];
                        m_r1[s]      <= dispatch_src1_ready[k] | on_cdb(dispatch_src1[k]);
                        m_r2[s]      <= dispatch_src2_ready[k] | on_cdb(dispatch_src2[k]);
                    end
                    k++;
                end
            end
        end
    end

    a_open: assert property (@(posedge clock) disable iff (reset) open_entries == exp_open)
        else report_value("open_entries", 32'($sampled(exp_open)), 32'($sampled(open_entries)));

    for (genvar u = 0; u < NU; u++) begin : g_unit
        a_valid: assert property (@(posedge clock) disable iff (reset) act_v[u] == exp_v[u])
            else report_value(port_name(u, "valid"), 32'($sampled(exp_v[u])),
                              32'($sampled(act_v[u])));
        a_dest: assert property (@(posedge clock) disable iff (reset)
                                 !exp_v[u] || act_dest[u] == exp_dest[u])
            else report_value(port_name(u, "dest"), 32'($sampled(exp_dest[u])),
                              32'($sampled(act_dest[u])));
        a_payload: assert property (@(posedge clock) disable iff (reset)
                                    !exp_v[u] || act_payload[u] == exp_payload[u])
            else report_value(port_name(u, "payload"), 32'($sampled(exp_payload[u])),
                              32'($sampled(act_payload[u])));
    end

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // called at a falling edge, drives at the next rising edge, returns at the falling edge
    task automatic cycle_drive(input int lanes, input bit mix, input logic [1:0] cls,
                               input logic s1_rdy, input logic [5:0] s1_tag,
                               input logic [1:0] cdb_on, input logic [5:0] cdb_t0,
                               input logic [3:0] busy);
        int room;
        int n;
        // lanes still pending on the inputs also consume credit
        room = D - $countones(m_valid) - $countones(dispatch_valid);
        n = (lanes < room) ? lanes : room;
        if (n < 0) begin
            n = 0;
        end
        @(posedge clock);
        for (int l = 0; l < W; l++) begin
            dispatch_valid[l]      <= (l < n);
            dispatch_class[l]      <= mix ? `RS_CLASS_BITS'($urandom_range(0, 2)) : cls;
            dispatch_dest[l]       <= `RS_TAG_BITS'($urandom_range(0, 63));
            dispatch_src1[l]       <= mix ? `RS_TAG_BITS'($urandom_range(0, 7)) : s1_tag;
            dispatch_src1_ready[l] <= mix ? 1'($urandom_range(0, 1)) : s1_rdy;
            dispatch_src2[l]       <= `RS_TAG_BITS'($urandom_range(0, 7));
            dispatch_src2_ready[l] <= mix ? 1'($urandom_range(0, 1)) : 1'b1;
            dispatch_payload[l]    <= next_payload + `RS_PAYLOAD_BITS'(l);
        end
        next_payload = next_payload + `RS_PAYLOAD_BITS'(n);
        dispatched_total += n;
        cdb_valid  <= cdb_on;
        cdb_tag[0] <= cdb_t0;
        cdb_tag[1] <= `RS_TAG_BITS'($urandom_range(0, 7));
        {mem_busy, mult_busy, alu_busy} <= busy;
        @(negedge clock);
    endtask

    task automatic idle(input logic [3:0] busy);
        cycle_drive(0, 1'b0, `RS_CLASS_ALU, 1'b1, '0, 2'b00, '0, busy);
    endtask

    // units free, every tag broadcast in turn until the model is empty
    task automatic drain_queue();
        int cycles;
        cycles = 0;
        // lanes still on the inputs land at the next edge
        while (m_valid != '0 || dispatch_valid != '0) begin
            if (cycles == DRAIN_LIMIT) begin
                report_text("timeout: the queue did not drain with all units idle");
            end
            cycle_drive(0, 1'b0, `RS_CLASS_ALU, 1'b1, '0, 2'b11,
                        `RS_TAG_BITS'(cycles % 8), '0);
            cycles++;
        end
    endtask

    initial begin
        seed_value          = $urandom(SEED);
        reset               = 1'b1;
        dispatch_valid      = '0;
        dispatch_class      = '0;
        dispatch_dest       = '0;
        dispatch_src1       = '0;
        dispatch_src1_ready = '0;
        dispatch_src2       = '0;
        dispatch_src2_ready = '0;
        dispatch_payload    = '0;
        cdb_valid           = '0;
        cdb_tag             = '0;
        alu_busy            = '0;
        mult_busy           = '0;
        mem_busy            = '0;
        next_payload        = '0;
        dispatched_total    = 0;
        issued_total        = 0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        repeat (3) idle('0);
        // single and paired ready alu ops
        cycle_drive(1, 1'b0, `RS_CLASS_ALU, 1'b1, '0, 2'b00, '0, '0);
        idle('0);
        cycle_drive(2, 1'b0, `RS_CLASS_ALU, 1'b1, '0, 2'b00, '0, '0);
        repeat (2) idle('0);
        // src1 waits for tag 5, then a bypass wakeup on tag 6
        cycle_drive(1, 1'b0, `RS_CLASS_ALU, 1'b0, 6'd5, 2'b00, '0, '0);
        repeat (3) idle('0);
        cycle_drive(0, 1'b0, `RS_CLASS_ALU, 1'b1, '0, 2'b01, 6'd5, '0);
        idle('0);
        cycle_drive(1, 1'b0, `RS_CLASS_ALU, 1'b0, 6'd6, 2'b01, 6'd6, '0);
        repeat (2) idle('0);
        // mult ops held back by a busy multiplier
        cycle_drive(2, 1'b0, `RS_CLASS_MULT, 1'b1, '0, 2'b00, '0, 4'b0100);
        cycle_drive(1, 1'b0, `RS_CLASS_MULT, 1'b1, '0, 2'b00, '0, 4'b0100);
        repeat (3) idle(4'b0100);
        drain_queue();
        // fill to zero credit with every unit busy
        repeat (8) cycle_drive(2, 1'b0, `RS_CLASS_MEM, 1'b1, '0, 2'b00, '0, 4'b1111);
        idle(4'b1111);
        drain_queue();
        repeat (RANDOM_CYCLES) begin
            cycle_drive($urandom_range(0, 2), 1'b1, `RS_CLASS_ALU, 1'b1, '0,
                        2'($urandom), `RS_TAG_BITS'($urandom_range(0, 7)),
                        4'($urandom & $urandom));
        end
        drain_queue();
        idle('0);
        if (issued_total != dispatched_total) begin
            report_value("issued payload count", 32'(dispatched_total), 32'(issued_total));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rs_props.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module rs_props (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic [`RS_NUM_ALU-1:0]                          alu_busy,
    input  logic [`RS_NUM_MULT-1:0]                         mult_busy,
    input  logic [`RS_NUM_MEM-1:0]                          mem_busy,
    input  logic [`RS_OPEN_BITS-1:0]                        open_entries,
    input  logic [`RS_NUM_ALU-1:0]                          alu_issue_valid,
    input  logic [`RS_NUM_ALU-1:0][`RS_PAYLOAD_BITS-1:0]    alu_issue_payload,
    input  logic [`RS_NUM_MULT-1:0]                         mult_issue_valid,
    input  logic [`RS_NUM_MULT-1:0][`RS_PAYLOAD_BITS-1:0]   mult_issue_payload,
    input  logic [`RS_NUM_MEM-1:0]                          mem_issue_valid,
    input  logic [`RS_NUM_MEM-1:0][`RS_PAYLOAD_BITS-1:0]    mem_issue_payload
);

    localparam int NU = `RS_NUM_ALU + `RS_NUM_MULT + `RS_NUM_MEM;

    logic [NU-1:0]                          valid_all;
    logic [NU-1:0]                          busy_all;
    logic [NU-1:0][`RS_PAYLOAD_BITS-1:0]    payload_all;
    logic                                   payload_clash;

    assign valid_all   = {mem_issue_valid, mult_issue_valid, alu_issue_valid};
    assign busy_all    = {mem_busy, mult_busy, alu_busy};
    assign payload_all = {mem_issue_payload, mult_issue_payload, alu_issue_payload};

    // any pair of active units carrying the same micro-op
    always_comb begin
        payload_clash = 1'b0;
        for (int a = 0; a < NU; a++) begin
            for (int b = a + 1; b < NU; b++) begin
                if (valid_all[a] && valid_all[b] && payload_all[a] == payload_all[b]) begin
                    payload_clash = 1'b1;
                end
            end
        end
    end

    a_busy_idle: assert property (@(posedge clock) disable iff (reset)
                                  (valid_all & busy_all) == '0)
        else $error("issue valid on a busy unit");

    a_open_range: assert property (@(posedge clock) disable iff (reset)
                                   open_entries <= `RS_WIDTH)
        else $error("open_entries above the dispatch width");

    a_unique_payload: assert property (@(posedge clock) disable iff (reset) !payload_clash)
        else $error("two units issue the same payload");

endmodule

bind rs rs_props i_props (
    .clock(clock),
    .reset(reset),
    .alu_busy(alu_busy),
    .mult_busy(mult_busy),
    .mem_busy(mem_busy),
    .open_entries(open_entries),
    .alu_issue_valid(alu_issue_valid),
    .alu_issue_payload(alu_issue_payload),
    .mult_issue_valid(mult_issue_valid),
    .mult_issue_payload(mult_issue_payload),
    .mem_issue_valid(mem_issue_valid),
    .mem_issue_payload(mem_issue_payload)
);

`default_nettype wire

// ==== rs.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module rs (
    input  logic                                            clock,
    input  logic                                            reset,

    input  logic [`RS_WIDTH-1:0]                            dispatch_valid,
    input  logic [`RS_WIDTH-1:0][`RS_CLASS_BITS-1:0]        dispatch_class,
    input  logic [`RS_WIDTH-1:0][`RS_TAG_BITS-1:0]          dispatch_dest,
    input  logic [`RS_WIDTH-1:0][`RS_TAG_BITS-1:0]          dispatch_src1,
    input  logic [`RS_WIDTH-1:0]                            dispatch_src1_ready,
    input  logic [`RS_WIDTH-1:0][`RS_TAG_BITS-1:0]          dispatch_src2,
    input  logic [`RS_WIDTH-1:0]                            dispatch_src2_ready,
    input  logic [`RS_WIDTH-1:0][`RS_PAYLOAD_BITS-1:0]      dispatch_payload,

    input  logic [`RS_CDB_PORTS-1:0]                        cdb_valid,
    input  logic [`RS_CDB_PORTS-1:0][`RS_TAG_BITS-1:0]      cdb_tag,

    input  logic [`RS_NUM_ALU-1:0]                          alu_busy,
    input  logic [`RS_NUM_MULT-1:0]                         mult_busy,
    input  logic [`RS_NUM_MEM-1:0]                          mem_busy,

    output logic [`RS_OPEN_BITS-1:0]                        open_entries,

    output logic [`RS_NUM_ALU-1:0]                          alu_issue_valid,
    output logic [`RS_NUM_ALU-1:0][`RS_TAG_BITS-1:0]        alu_issue_dest,
    output logic [`RS_NUM_ALU-1:0][`RS_PAYLOAD_BITS-1:0]    alu_issue_payload,
    output logic [`RS_NUM_MULT-1:0]                         mult_issue_valid,
    output logic [`RS_NUM_MULT-1:0][`RS_TAG_BITS-1:0]       mult_issue_dest,
    output logic [`RS_NUM_MULT-1:0][`RS_PAYLOAD_BITS-1:0]   mult_issue_payload,
    output logic [`RS_NUM_MEM-1:0]                          mem_issue_valid,
    output logic [`RS_NUM_MEM-1:0][`RS_TAG_BITS-1:0]        mem_issue_dest,
    output logic [`RS_NUM_MEM-1:0][`RS_PAYLOAD_BITS-1:0]    mem_issue_payload
);

    logic [`RS_DEPTH-1:0]                       free_slots;
    logic [`RS_WIDTH-1:0][`RS_DEPTH-1:0]        dispatch_slot;
    logic [`RS_DEPTH-1:0]                       alu_ready_mask;
    logic [`RS_DEPTH-1:0]                       mult_ready_mask;
    logic [`RS_DEPTH-1:0]                       mem_ready_mask;
    logic [`RS_DEPTH-1:0][`RS_TAG_BITS-1:0]     slot_dest;
    logic [`RS_DEPTH-1:0][`RS_PAYLOAD_BITS-1:0] slot_payload;
    logic [`RS_DEPTH-1:0]                       alu_granted;
    logic [`RS_DEPTH-1:0]                       mult_granted;
    logic [`RS_DEPTH-1:0]                       mem_granted;
    logic [`RS_DEPTH-1:0]                       issued_slots;

    // classes never share a slot, so the grants are disjoint
    assign issued_slots = alu_granted | mult_granted | mem_granted;

    rs_entries i_entries (
        .clock(clock),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .dispatch_class(dispatch_class),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src1_ready(dispatch_src1_ready),
        .dispatch_src2(dispatch_src2),
        .dispatch_src2_ready(dispatch_src2_ready),
        .dispatch_payload(dispatch_payload),
        .dispatch_slot(dispatch_slot),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .issued_slots(issued_slots),
        .free_slots(free_slots),
        .alu_ready_mask(alu_ready_mask),
        .mult_ready_mask(mult_ready_mask),
        .mem_ready_mask(mem_ready_mask),
        .slot_dest(slot_dest),
        .slot_payload(slot_payload),
        .open_entries(open_entries)
    );

    rs_slot_alloc i_slot_alloc (
        .free_slots(free_slots),
        .dispatch_slot(dispatch_slot)
    );

    rs_issue_select #(.NUM_FU(`RS_NUM_ALU)) alu_select (
        .ready_mask(alu_ready_mask),
        .fu_busy(alu_busy),
        .slot_dest(slot_dest),
        .slot_payload(slot_payload),
        .issue_valid(alu_issue_valid),
        .issue_dest(alu_issue_dest),
        .issue_payload(alu_issue_payload),
        .granted_slots(alu_granted)
    );

    rs_issue_select #(.NUM_FU(`RS_NUM_MULT)) mult_select (
        .ready_mask(mult_ready_mask),
        .fu_busy(mult_busy),
        .slot_dest(slot_dest),
        .slot_payload(slot_payload),
        .issue_valid(mult_issue_valid),
        .issue_dest(mult_issue_dest),
        .issue_payload(mult_issue_payload),
        .granted_slots(mult_granted)
    );

    rs_issue_select #(.NUM_FU(`RS_NUM_MEM)) mem_select (
        .ready_mask(mem_ready_mask),
        .fu_busy(mem_busy),
        .slot_dest(slot_dest),
        .slot_payload(slot_payload),
        .issue_valid(mem_issue_valid),
        .issue_dest(mem_issue_dest),
        .issue_payload(mem_issue_payload),
        .granted_slots(mem_granted)
    );

endmodule

`default_nettype wire

// ==== rs_issue_select.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module rs_issue_select #(
    parameter int NUM_FU = 1
) (
    input  logic [`RS_DEPTH-1:0]                            ready_mask,
    input  logic [NUM_FU-1:0]                               fu_busy,
    input  logic [`RS_DEPTH-1:0][`RS_TAG_BITS-1:0]          slot_dest,
    input  logic [`RS_DEPTH-1:0][`RS_PAYLOAD_BITS-1:0]      slot_payload,

    output logic [NUM_FU-1:0]                               issue_valid,
    output logic [NUM_FU-1:0][`RS_TAG_BITS-1:0]             issue_dest,
    output logic [NUM_FU-1:0][`RS_PAYLOAD_BITS-1:0]         issue_payload,
    output logic [`RS_DEPTH-1:0]                            granted_slots
);

    logic [NUM_FU-1:0][`RS_DEPTH-1:0]   unit_grant;
    logic [`RS_DEPTH-1:0]               remaining;

    // units in index order, each takes the lowest request left
    always_comb begin
        remaining     = ready_mask;
        granted_slots = '0;
        for (int u = 0; u < NUM_FU; u++) begin
            if (fu_busy[u]) begin
                unit_grant[u] = '0;
            end else begin
                unit_grant[u] = rs_pkg::lowest_set(remaining);
            end
            remaining     = remaining & ~unit_grant[u];
            granted_slots = granted_slots | unit_grant[u];
        end
    end

    // one-hot mux of the granted slot onto each unit
    always_comb begin
        for (int u = 0; u < NUM_FU; u++) begin
            issue_valid[u]   = |unit_grant[u];
            issue_dest[u]    = '0;
            issue_payload[u] = '0;
            for (int s = 0; s < `RS_DEPTH; s++) begin
                if (unit_grant[u][s]) begin
                    issue_dest[u]    = slot_dest[s];
                    issue_payload[u] = slot_payload[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rs_slot_alloc.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module rs_slot_alloc (
    input  logic [`RS_DEPTH-1:0]                    free_slots,
    output logic [`RS_WIDTH-1:0][`RS_DEPTH-1:0]     dispatch_slot
);

    // free mask still open after each lane has taken its slot
    logic [`RS_DEPTH-1:0] remaining;

    always_comb begin
        remaining = free_slots;
        for (int l = 0; l < `RS_WIDTH; l++) begin
            // lane l ends up with the l-th lowest free slot
            dispatch_slot[l] = rs_pkg::lowest_set(remaining);
            remaining        = remaining & ~dispatch_slot[l];
        end
    end

endmodule

`default_nettype wire

// ==== rs_entries.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module rs_entries (
    input  logic                                            clock,
    input  logic                                            reset,

    input  logic [`RS_WIDTH-1:0]                            dispatch_valid,
    input  logic [`RS_WIDTH-1:0][`RS_CLASS_BITS-1:0]        dispatch_class,
    input  logic [`RS_WIDTH-1:0][`RS_TAG_BITS-1:0]          dispatch_dest,
    input  logic [`RS_WIDTH-1:0][`RS_TAG_BITS-1:0]          dispatch_src1,
    input  logic [`RS_WIDTH-1:0]                            dispatch_src1_ready,
    input  logic [`RS_WIDTH-1:0][`RS_TAG_BITS-1:0]          dispatch_src2,
    input  logic [`RS_WIDTH-1:0]                            dispatch_src2_ready,
    input  logic [`RS_WIDTH-1:0][`RS_PAYLOAD_BITS-1:0]      dispatch_payload,
    input  logic [`RS_WIDTH-1:0][`RS_DEPTH-1:0]             dispatch_slot,

    input  logic [`RS_CDB_PORTS-1:0]                        cdb_valid,
    input  logic [`RS_CDB_PORTS-1:0][`RS_TAG_BITS-1:0]      cdb_tag,

    input  logic [`RS_DEPTH-1:0]                            issued_slots,

    output logic [`RS_DEPTH-1:0]                            free_slots,
    output logic [`RS_DEPTH-1:0]                            alu_ready_mask,
    output logic [`RS_DEPTH-1:0]                            mult_ready_mask,
    output logic [`RS_DEPTH-1:0]                            mem_ready_mask,
    output logic [`RS_DEPTH-1:0][`RS_TAG_BITS-1:0]          slot_dest,
    output logic [`RS_DEPTH-1:0][`RS_PAYLOAD_BITS-1:0]      slot_payload,
    output logic [`RS_OPEN_BITS-1:0]                        open_entries
);

    logic [`RS_DEPTH-1:0]                       slot_valid;
    logic [`RS_DEPTH-1:0][`RS_CLASS_BITS-1:0]   slot_class;
    logic [`RS_DEPTH-1:0][`RS_TAG_BITS-1:0]     slot_src1;
    logic [`RS_DEPTH-1:0]                       slot_src1_ready;
    logic [`RS_DEPTH-1:0][`RS_TAG_BITS-1:0]     slot_src2;
    logic [`RS_DEPTH-1:0]                       slot_src2_ready;
    logic [`RS_DEPTH-1:0]                       written_slots;
    logic [`RS_COUNT_BITS-1:0]                  free_count;
    logic [`RS_DEPTH-1:0]                       slot_ready;

    // true when any valid broadcast carries this tag
    function automatic logic tag_woken(input logic [`RS_TAG_BITS-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `RS_CDB_PORTS; p++) begin
            if (cdb_valid[p] && (cdb_tag[p] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        written_slots = '0;
        for (int l = 0; l < `RS_WIDTH; l++) begin
            if (dispatch_valid[l]) begin
                written_slots = written_slots | dispatch_slot[l];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_valid <= '0;
        end else begin
            slot_valid <= (slot_valid & ~issued_slots) | written_slots;
        end
    end

    // wakeup of stored sources, then dispatch writes override
    always_ff @(posedge clock) begin
        for (int s = 0; s < `RS_DEPTH; s++) begin
            if (tag_woken(slot_src1[s])) begin
                slot_src1_ready[s] <= 1'b1;
            end
            if (tag_woken(slot_src2[s])) begin
                slot_src2_ready[s] <= 1'b1;
            end
            for (int l = 0; l < `RS_WIDTH; l++) begin
                if (dispatch_valid[l] && dispatch_slot[l][s]) begin
                    slot_class[s]      <= dispatch_class[l];
                    slot_dest[s]       <= dispatch_dest[l];
                    slot_src1[s]       <= dispatch_src1[l];
                    slot_src2[s]       <= dispatch_src2[l];
                    slot_payload[s]    <= dispatch_payload[l];
                    // same-cycle bypass so no broadcast is missed
                    slot_src1_ready[s] <= dispatch_src1_ready[l] | tag_woken(dispatch_src1[l]);
                    slot_src2_ready[s] <= dispatch_src2_ready[l] | tag_woken(dispatch_src2[l]);
                end
            end
        end
    end

    assign slot_ready = slot_valid & slot_src1_ready & slot_src2_ready;

    // class split of the ready requests
    always_comb begin
        for (int s = 0; s < `RS_DEPTH; s++) begin
            alu_ready_mask[s]  = slot_ready[s] && (slot_class[s] == `RS_CLASS_ALU);
            mult_ready_mask[s] = slot_ready[s] && (slot_class[s] == `RS_CLASS_MULT);
            mem_ready_mask[s]  = slot_ready[s] && (slot_class[s] == `RS_CLASS_MEM);
        end
    end

    assign free_slots = ~slot_valid;

    // credit from registered occupancy only
    assign free_count   = `RS_COUNT_BITS'(`RS_DEPTH) - rs_pkg::count_ones(slot_valid);
    assign open_entries = (free_count > `RS_WIDTH) ? `RS_OPEN_BITS'(`RS_WIDTH)
                                                   : `RS_OPEN_BITS'(free_count);

endmodule

`default_nettype wire

// ==== rs_pkg.sv ====
`default_nettype none

`include "rs_defs.svh"

package rs_pkg;

    // one-hot of the lowest set bit, zero when the vector is empty
    function automatic logic [`RS_DEPTH-1:0] lowest_set(
        input logic [`RS_DEPTH-1:0] vec
    );
        logic [`RS_DEPTH-1:0] result;
        // two's complement isolates the lowest one
        result = vec & (~vec + 1'b1);
        return result;
    endfunction

    // population count over a slot mask
    function automatic logic [`RS_COUNT_BITS-1:0] count_ones(
        input logic [`RS_DEPTH-1:0] vec
    );
        logic [`RS_COUNT_BITS-1:0] total;
        total = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            total = total + `RS_COUNT_BITS'(vec[i]);
        end
        return total;
    endfunction

endpackage

`default_nettype wire

// ==== rs_defs.svh ====
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// station geometry
`define RS_DEPTH          8
`define RS_WIDTH          2
`define RS_CDB_PORTS      2

// field widths
`define RS_TAG_BITS       6
`define RS_PAYLOAD_BITS   16
`define RS_CLASS_BITS     2

// derived counter widths
`define RS_COUNT_BITS     ($clog2(`RS_DEPTH + 1))
`define RS_OPEN_BITS      ($clog2(`RS_WIDTH + 1))

// functional-unit class codes
`define RS_CLASS_ALU      2'd0
`define RS_CLASS_MULT     2'd1
`define RS_CLASS_MEM      2'd2

// units per class
`define RS_NUM_ALU        2
`define RS_NUM_MULT       1
`define RS_NUM_MEM        1

`endif
